/* triviumTop.f */
hw/triviumPkg.sv
hw/keyIvLoader.sv
hw/triviumCore.sv
hw/keystreamPacker.sv
hw/triviumTop.sv
dv/triviumChecker.sv
dv/triviumTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module triviumTb \
    -f triviumTop.f

./obj_dir/VtriviumTb | tee "$LOG"

if grep -q "Test FAILED" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi
echo "Simulation passed"

/* dv/triviumTb.sv */
`timescale 1ns/1ps

module triviumTb import triviumPkg::*; ();

    localparam int BlockBits = 256;   // DUT default
    localparam int Timeout   = 3000;  // Cycles allowed for one run

    logic                 CLK;
    logic                 RSTn;
    logic                 EN;
    keyT                  Kin;
    logic                 Krdy;
    ivT                   Din;
    logic                 Drdy;
    logic [BlockBits-1:0] Dout;
    logic                 BSY;
    logic                 Kvld;
    logic                 Dvld;

    int          checkErrors;
    int          checkBlocks;
    int          tbFails;
    int          lastErrs;
    int          blocksBefore;
    logic        keyHeld;  // Kvld must stay high once set
    logic [31:0] lfsr;

    always #50 CLK = ~CLK;

    triviumTop triviumTop_inst (
        .CLK  (CLK),
        .RSTn (RSTn),
        .EN   (EN),
        .Kin  (Kin),
        .Krdy (Krdy),
        .Din  (Din),
        .Drdy (Drdy),
        .Dout (Dout),
        .BSY  (BSY),
        .Kvld (Kvld),
        .Dvld (Dvld)
    );

    triviumChecker #(
        .BlockBits (BlockBits)
    ) triviumChecker_inst (
        .CLK    (CLK),
        .RSTn   (RSTn),
        .EN     (EN),
        .Kin    (Kin),
        .Krdy   (Krdy),
        .Din    (Din),
        .Drdy   (Drdy),
        .Dout   (Dout),
        .BSY    (BSY),
        .Kvld   (Kvld),
        .Dvld   (Dvld),
        .errors (checkErrors),
        .blocks (checkBlocks)
    );

    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;  // Taps 32, 30, 26, 25
        end
        return s >> 1;
    endfunction

    function automatic logic [79:0] takeBits(input int n);
        logic [79:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[78:0], lfsr[0]};
            lfsr = galoisStep(lfsr);
        end
        return r;
    endfunction

    task automatic expectLevel(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s expected %b, got %b", $time, name, exp, got);
            tbFails++;
        end
    endtask

    task automatic loadKey(input keyT k);
        @(negedge CLK);
        EN   = 1'b1;
        Kin  = k;
        Krdy = 1'b1;
        @(negedge CLK);
        Krdy    = 1'b0;
        keyHeld = 1'b1;
    endtask

    task automatic startRun(input ivT v);
        @(negedge CLK);
        EN   = 1'b1;
        Din  = v;
        Drdy = 1'b1;
        @(negedge CLK);
        Drdy = 1'b0;
    endtask

    task automatic waitDvld(input logic stall);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < Timeout) begin
            @(negedge CLK);
            if (keyHeld) begin
                expectLevel("Kvld", Kvld, 1'b1);
            end
            if (Dvld) begin
                seen = 1'b1;
            end else if (stall) begin
                EN = (takeBits(2) != '0);  // Low on about one cycle in four
            end
            n++;
        end
        EN = 1'b1;
        if (!seen) begin
            $display("Timed out after %0d cycles waiting for Dvld", Timeout);
            tbFails++;
        end
    endtask

    task automatic expectNoRun(input int cycles);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < cycles) begin
            @(negedge CLK);
            seen = BSY || Dvld;
            n++;
        end
        if (seen) begin
            $display("BSY or Dvld rose at time %0t although no key was loaded", $time);
            tbFails++;
        end
    endtask

    task automatic idleCycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge CLK);
        end
    endtask

    task automatic reportTest(input string name);
        int errs;
        @(negedge CLK);  // Lets the checker take the last Dvld
        errs = checkErrors + tbFails;
        if (errs == lastErrs) begin
            $display("%s: passed, %0d blocks checked so far", name, checkBlocks);
        end else begin
            $display("%s: failed with %0d errors", name, errs - lastErrs);
        end
        lastErrs = errs;
    endtask

    initial begin
        CLK     = 1'b0;
        RSTn    = 1'b0;
        EN      = 1'b1;
        Kin     = '0;
        Krdy    = 1'b0;
        Din     = '0;
        Drdy    = 1'b0;
        tbFails  = 0;
        lastErrs = 0;
        keyHeld  = 1'b0;
        lfsr     = 32'h4804_0ff8;
        idleCycles(5);
        RSTn = 1'b1;

        expectLevel("BSY", BSY, 1'b0);
        expectLevel("Kvld", Kvld, 1'b0);
        expectLevel("Dvld", Dvld, 1'b0);
        startRun(takeBits(80));  // No key stored yet
        expectNoRun(200);
        reportTest("Reset");

        loadKey(takeBits(80));
        startRun(takeBits(80));
        expectLevel("BSY", BSY, 1'b1);
        waitDvld(1'b0);
        reportTest("Single block");

        for (int i = 0; i < 3; i++) begin
            startRun(takeBits(80));
            waitDvld(1'b0);
        end
        reportTest("Key reuse");

        for (int i = 0; i < 2; i++) begin
            startRun(takeBits(80));
            waitDvld(1'b1);
        end
        reportTest("Stall");

        startRun(takeBits(80));
        blocksBefore = checkBlocks;
        idleCycles(20);
        loadKey(takeBits(80));    // Both land while BSY is high
        startRun(takeBits(80));
        waitDvld(1'b0);
        idleCycles(300);
        if (checkBlocks != blocksBefore + 1) begin
            $display("Expected one block after the busy strobes, saw %0d",
                     checkBlocks - blocksBefore);
            tbFails++;
        end
        startRun(takeBits(80));   // Still runs on the key from before the busy strobes
        waitDvld(1'b0);
        reportTest("Strobes while busy");

        loadKey(takeBits(80));
        startRun(takeBits(80));
        waitDvld(1'b0);
        idleCycles(2);
        reportTest("Key change");

        $display("Blocks checked: %0d, errors: %0d", checkBlocks, checkErrors + tbFails);
        if (checkErrors + tbFails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* dv/triviumChecker.sv */
`timescale 1ns/1ps

module triviumChecker import triviumPkg::*; #(
    parameter int BlockBits = 256
) (
    input  logic                 CLK,
    input  logic                 RSTn,
    input  logic                 EN,
    input  keyT                  Kin,
    input  logic                 Krdy,
    input  ivT                   Din,
    input  logic                 Drdy,
    input  logic [BlockBits-1:0] Dout,
    input  logic                 BSY,
    input  logic                 Kvld,
    input  logic                 Dvld,
    output int                   errors,
    output int                   blocks
);

    keyT                  expKey;
    logic                 expKvld;
    logic                 expBusy;   // Run accepted and its block not yet seen
    logic [BlockBits-1:0] expBlock;
    logic                 prevEn;
    logic                 prevDvld;
    logic                 busyNow;
    logic                 keyTake;
    logic                 ivTake;

    assign busyNow = expBusy && !Dvld;  // BSY drops on the Dvld edge
    assign keyTake = Krdy && !busyNow;
    assign ivTake  = Drdy && expKvld && !busyNow;

    // Byte 0 of the port word becomes the top byte
    function automatic keyT reverseBytes(input keyT w);
        keyT r;
        for (int b = 0; b < KeyBits / 8; b++) begin
            r[8*b +: 8] = w[KeyBits-8-8*b +: 8];
        end
        return r;
    endfunction

    // Bit-serial Trivium in s1..s288 numbering with one round per bit
    function automatic logic [BlockBits-1:0] refBlock(input keyT key, input ivT iv,
                                                       input int nBits);
        logic [288:1]         s;
        logic [BlockBits-1:0] blk;
        logic                 t1;
        logic                 t2;
        logic                 t3;
        s          = '0;
        s[80:1]    = reverseBytes(key);
        s[173:94]  = reverseBytes(iv);
        s[288:286] = 3'b111;
        blk        = '0;
        for (int r = 0; r < InitRounds + nBits; r++) begin
            t1 = s[66] ^ s[93];
            t2 = s[162] ^ s[177];
            t3 = s[243] ^ s[288];
            if (r >= InitRounds) begin
                blk[nBits-1-(r-InitRounds)] = t1 ^ t2 ^ t3;  // First bit at MSB
            end
            t1 = t1 ^ (s[91] & s[92]) ^ s[171];
            t2 = t2 ^ (s[175] & s[176]) ^ s[264];
            t3 = t3 ^ (s[286] & s[287]) ^ s[69];
            s[93:1]    = {s[92:1], t3};
            s[177:94]  = {s[176:94], t1};
            s[288:178] = {s[287:178], t2};
        end
        return blk;
    endfunction

    always @(posedge CLK) begin : compare
        int  errNow;
        keyT runKey;
        errNow = 0;
        runKey = keyTake ? Kin : expKey;  // Same-edge key is loaded first
        if (!RSTn) begin
            expKvld  <= 1'b0;
            expBusy  <= 1'b0;
            prevEn   <= 1'b1;
            prevDvld <= 1'b0;
            errors   <= 0;
            blocks   <= 0;
        end else begin
            if (BSY !== busyNow) begin
                $display("** Error at time %0t: BSY expected %b, got %b", $time, busyNow, BSY);
                errNow++;
            end
            if (Kvld !== expKvld) begin
                $display("** Error at time %0t: Kvld expected %b, got %b", $time, expKvld, Kvld);
                errNow++;
            end
            if (Dvld && !prevDvld && !prevEn) begin
                $display("Dvld rose at time %0t on a cycle with EN low", $time);
                errNow++;
            end
            if (EN) begin
                if (keyTake) begin
                    expKey  <= Kin;
                    expKvld <= 1'b1;
                end
                if (ivTake) begin
                    expBusy  <= 1'b1;
                    expBlock <= refBlock(runKey, Din, BlockBits);
                end else if (Dvld) begin
                    expBusy <= 1'b0;
                end
                if (Dvld) begin  // Each pulse is consumed on one enabled edge
                    blocks <= blocks + 1;
                    if (!expBusy) begin
                        $display("Dvld at time %0t with no run in progress", $time);
                        errNow++;
                    end else if (Dout !== expBlock) begin
                        $display("** Error at time %0t: Dout expected %h, got %h",
                                 $time, expBlock, Dout);
                        errNow++;
                    end
                end
            end
            prevEn   <= EN;
            prevDvld <= Dvld;
            errors   <= errors + errNow;
        end
    end

endmodule

/* hw/triviumTop.sv */
`timescale 1ns/1ps

module triviumTop import triviumPkg::*; #(
    parameter int BitsPerCycle = 8,    // Power-of-two rounds per clock
    parameter int BlockBits    = 256   // Keystream bits per run
) (
    input  logic                 CLK,
    input  logic                 RSTn,
    input  logic                 EN,
    input  keyT                  Kin,
    input  logic                 Krdy,
    input  ivT                   Din,
    input  logic                 Drdy,
    output logic [BlockBits-1:0] Dout,
    output logic                 BSY,
    output logic                 Kvld,
    output logic                 Dvld
);

    initVecT                 loadVec;
    logic                    start;
    logic [BitsPerCycle-1:0] ksBits;
    logic                    ksValid;
    logic                    runDone;

    keyIvLoader keyIvLoader_inst (
        .CLK     (CLK),
        .RSTn    (RSTn),
        .EN      (EN),
        .Kin     (Kin),
        .Krdy    (Krdy),
        .Din     (Din),
        .Drdy    (Drdy),
        .runDone (runDone),
        .loadVec (loadVec),
        .start   (start),
        .Kvld    (Kvld),
        .BSY     (BSY)
    );

    triviumCore #(
        .BitsPerCycle (BitsPerCycle)
    ) triviumCore_inst (
        .CLK     (CLK),
        .RSTn    (RSTn),
        .EN      (EN),
        .loadVec (loadVec),
        .start   (start),
        .runDone (runDone),
        .ksBits  (ksBits),
        .ksValid (ksValid)
    );

    // Ends the run when the block is full
    keystreamPacker #(
        .BitsPerCycle (BitsPerCycle),
        .BlockBits    (BlockBits)
    ) keystreamPacker_inst (
        .CLK     (CLK),
        .RSTn    (RSTn),
        .EN      (EN),
        .ksBits  (ksBits),
        .ksValid (ksValid),
        .Dout    (Dout),
        .Dvld    (Dvld),
        .runDone (runDone)
    );

endmodule

/* hw/keystreamPacker.sv */
`timescale 1ns/1ps

module keystreamPacker #(
    parameter int BitsPerCycle = 8,
    parameter int BlockBits    = 256
) (
    input  logic                    CLK,
    input  logic                    RSTn,
    input  logic                    EN,
    input  logic [BitsPerCycle-1:0] ksBits,
    input  logic                    ksValid,
    output logic [BlockBits-1:0]    Dout,
    output logic                    Dvld,
    output logic                    runDone
);

    localparam int Groups = BlockBits / BitsPerCycle;  // Groups per block
    localparam int CntW   = $clog2(Groups + 1);

    logic [BlockBits-1:0] asmReg;   // Block under assembly
    logic [BlockBits-1:0] asmNext;
    logic [CntW-1:0]      grpCnt;
    logic                 lastGrp;

    assign lastGrp = (grpCnt == CntW'(Groups - 1));
    assign asmNext = (asmReg << BitsPerCycle) | BlockBits'(ksBits);  // Oldest bits rise to MSB

    // Core and loader finish with the final group
    assign runDone = ksValid && lastGrp;

    always_ff @(posedge CLK) begin
        if (EN && ksValid) begin
            asmReg <= asmNext;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            grpCnt <= '0;
            Dvld   <= 1'b0;
            Dout   <= '0;
        end else if (EN) begin
            Dvld <= 1'b0;
            if (ksValid) begin
                if (lastGrp) begin
                    Dout   <= asmNext;  // Held until next block
                    Dvld   <= 1'b1;
                    grpCnt <= '0;
                end else begin
                    grpCnt <= grpCnt + 1'b1;
                end
            end
        end
    end

endmodule

/* hw/triviumCore.sv */
`timescale 1ns/1ps

module triviumCore import triviumPkg::*; #(
    parameter int BitsPerCycle = 8
) (
    input  logic                    CLK,
    input  logic                    RSTn,
    input  logic                    EN,
    input  initVecT                 loadVec,
    input  logic                    start,
    input  logic                    runDone,
    output logic [BitsPerCycle-1:0] ksBits,
    output logic                    ksValid
);

    localparam int CntW = $clog2(InitRounds + 1);

    trivStateT       state;
    trivStateT       stateNext;
    logic [CntW-1:0] roundCnt;  // Init rounds done so far
    logic            running;
    logic            initDone;

    assign initDone = (roundCnt == CntW'(InitRounds));
    assign ksValid  = running && initDone;

    // BitsPerCycle rounds chained within one clock
    always_comb begin : roundUnroll
        trivStateT s;
        logic      t1;
        logic      t2;
        logic      t3;
        s = state;
        for (int i = 0; i < BitsPerCycle; i++) begin
            t1 = s.flat[65] ^ s.flat[92];    // s66 ^ s93
            t2 = s.flat[161] ^ s.flat[176];  // s162 ^ s177
            t3 = s.flat[242] ^ s.flat[287];  // s243 ^ s288
            ksBits[BitsPerCycle-1-i] = t1 ^ t2 ^ t3;  // Earliest round on MSB
            t1 = t1 ^ (s.flat[90] & s.flat[91]) ^ s.flat[170];
            t2 = t2 ^ (s.flat[174] & s.flat[175]) ^ s.flat[263];
            t3 = t3 ^ (s.flat[285] & s.flat[286]) ^ s.flat[68];
            // Each register moves one place up and takes its feedback at the bottom
            s.regs.regA = {s.regs.regA[RegABits-2:0], t3};
            s.regs.regB = {s.regs.regB[RegBBits-2:0], t1};
            s.regs.regC = {s.regs.regC[RegCBits-2:0], t2};
        end
        stateNext = s;
    end

    // Idle, warm-up, then keystream until the packer is full
    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            running  <= 1'b0;
            roundCnt <= '0;
        end else if (EN) begin
            if (start) begin
                running  <= 1'b1;
                roundCnt <= '0;
            end else if (running) begin
                if (runDone) begin
                    running <= 1'b0;  // Block complete
                end else if (!initDone) begin
                    roundCnt <= roundCnt + CntW'(BitsPerCycle);
                end
            end
        end
    end

    // Cipher state
    always_ff @(posedge CLK) begin
        if (EN) begin
            if (start) begin
                // 111 on top, IV at s94..s173, key at s1..s80
                state.flat <= {3'b111, 112'b0, loadVec.iv, 13'b0, loadVec.key};
            end else if (running) begin
                state <= stateNext;
            end
        end
    end

endmodule

/* hw/keyIvLoader.sv */
`timescale 1ns/1ps

module keyIvLoader import triviumPkg::*; (
    input  logic    CLK,
    input  logic    RSTn,
    input  logic    EN,
    input  keyT     Kin,
    input  logic    Krdy,
    input  ivT      Din,
    input  logic    Drdy,
    input  logic    runDone,
    output initVecT loadVec,
    output logic    start,
    output logic    Kvld,
    output logic    BSY
);

    localparam int NumBytes = KeyBits / 8;

    logic keyAccept;
    logic ivAccept;

    // Byte 0 of the input word ends up in the top byte
    function automatic keyT byteRev(input keyT w);
        keyT r;
        for (int b = 0; b < NumBytes; b++) begin
            r[KeyBits-1-8*b -: 8] = w[8*b +: 8];
        end
        return r;
    endfunction

    assign keyAccept = Krdy && !BSY;
    assign ivAccept  = Drdy && Kvld && !BSY;  // Needs a stored key

    // Key and IV words
    always_ff @(posedge CLK) begin
        if (EN) begin
            if (keyAccept) begin
                loadVec.key <= byteRev(Kin);
            end
            if (ivAccept) begin
                loadVec.iv <= byteRev(Din);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            Kvld  <= 1'b0;
            BSY   <= 1'b0;
            start <= 1'b0;
        end else if (EN) begin
            start <= ivAccept;  // Single pulse per accepted IV
            if (keyAccept) begin
                Kvld <= 1'b1;   // Sticky until reset
            end
            if (ivAccept) begin
                BSY <= 1'b1;
            end else if (runDone) begin
                BSY <= 1'b0;    // Drops together with Dvld
            end
        end
    end

endmodule

/* hw/triviumPkg.sv */
package triviumPkg;

    // Cipher dimensions
    localparam int KeyBits    = 80;    // Key and IV width
    localparam int StateBits  = 288;   // Full Trivium state
    localparam int InitRounds = 1152;  // Warm-up rounds before keystream

    // Register lengths of the three NLFSRs
    localparam int RegABits = 93;
    localparam int RegBBits = 84;
    localparam int RegCBits = 111;

    typedef logic [KeyBits-1:0] keyT;  // Byte 0 in bits 7..0
    typedef logic [KeyBits-1:0] ivT;

    // Byte-reversed load request from loader to core
    typedef struct packed {
        keyT key;
        ivT  iv;
    } initVecT;

    // Register view of the state with regA at the low end
    typedef struct packed {
        logic [RegCBits-1:0] regC;  // s178..s288
        logic [RegBBits-1:0] regB;  // s94..s177
        logic [RegABits-1:0] regA;  // s1..s93
    } trivRegsT;

    // Flat index i holds Trivium bit s(i+1)
    typedef union packed {
        logic [StateBits-1:0] flat;  // Load and tap view
        trivRegsT             regs;  // Shift view
    } trivStateT;

endpackage
